// File: iq_pkg.sv
package iq_pkg;

  // Queue geometry.
  localparam int IQ_DEPTH = 8;

  // Physical register tag width.
  localparam int TAG_W = 6;

  // Opcode field width.
  localparam int OPC_W = 4;

  // Immediate field width in the immediate form.
  localparam int IMM_W = 6;

  // Full payload word, also the RAM data width.
  localparam int PAYLOAD_W = 1 + OPC_W + TAG_W + TAG_W + TAG_W;

  // Payload format selector.
  typedef enum logic [0:0] {
    FMT_REG = 1'b0,
    FMT_IMM = 1'b1
  } iq_fmt_e;

  // One payload word, decoded in two ways.
  // Both views share fmt, opcode and dest.
  // They differ only in the last field.
  typedef union packed {
    // Register form with two register sources.
    struct packed {
      iq_fmt_e            fmt;
      logic [OPC_W-1:0]   opcode;
      logic [TAG_W-1:0]   dest;
      logic [TAG_W-1:0]   src1;
      logic [TAG_W-1:0]   src2;
    } reg_form;
    // Immediate form.
    // Same src1 position, immediate in the src2 slot.
    struct packed {
      iq_fmt_e            fmt;
      logic [OPC_W-1:0]   opcode;
      logic [TAG_W-1:0]   dest;
      logic [TAG_W-1:0]   src1;
      logic [IMM_W-1:0]   imm;
    } imm_form;
  } iq_payload_u;

endpackage

// File: iq_entry_if.sv
interface iq_entry_if;
  import iq_pkg::*;

  // One-hot slot offered by the free list.
  logic [IQ_DEPTH-1:0] alloc_onehot;

  // Dispatch handshake completes this cycle.
  logic                alloc_fire;

  // One-hot entry chosen by select.
  logic [IQ_DEPTH-1:0] grant_onehot;

  // Issue handshake completes this cycle.
  logic                issue_fire;

  // Every entry busy.
  logic                full;

  // Free list side.
  modport freelist (
    output alloc_onehot,
    output full,
    input  alloc_fire,
    input  grant_onehot,
    input  issue_fire
  );

  // Wakeup and select side.
  modport select (
    input  alloc_onehot,
    input  full,
    output alloc_fire,
    output grant_onehot,
    output issue_fire
  );

endinterface

// File: one_hot_ram.sv
module one_hot_ram #(
  parameter int NUM_RD_PORTS = 1,
  parameter int NUM_WR_PORTS = 1
) (
  input  logic                                            clkGated,
  input  logic                                            reset,
  input  logic [NUM_RD_PORTS-1:0][iq_pkg::IQ_DEPTH-1:0]  rd_addr_i,
  output logic [NUM_RD_PORTS-1:0][iq_pkg::PAYLOAD_W-1:0] rd_data_o,
  input  logic [NUM_WR_PORTS-1:0][iq_pkg::IQ_DEPTH-1:0]  wr_addr_i,
  input  logic [NUM_WR_PORTS-1:0][iq_pkg::PAYLOAD_W-1:0] wr_data_i,
  input  logic [NUM_WR_PORTS-1:0]                         wr_en_i
);
  import iq_pkg::*;

  // Storage array, one word per word line.
  logic [PAYLOAD_W-1:0] mem [IQ_DEPTH];

  // Read through the word lines.
  // No line set falls back to word 0.
  always_comb
  begin
    for (int p = 0; p < NUM_RD_PORTS; p++)
    begin
      rd_data_o[p] = mem[0];
      for (int w = 0; w < IQ_DEPTH; w++)
      begin
        if (rd_addr_i[p][w])
        begin
          rd_data_o[p] = mem[w];
        end
      end
    end
  end

  // Write every word whose line is set.
  // Later ports win on a shared line.
  always_ff @(posedge clkGated)
  begin
    if (reset)
    begin
      for (int w = 0; w < IQ_DEPTH; w++)
      begin
        mem[w] <= '0;
      end
    end
    else
    begin
      for (int p = 0; p < NUM_WR_PORTS; p++)
      begin
        for (int w = 0; w < IQ_DEPTH; w++)
        begin
          if (wr_en_i[p] && wr_addr_i[p][w])
          begin
            mem[w] <= wr_data_i[p];
          end
        end
      end
    end
  end

  // Callers must keep read lines one-hot or idle.
  for (genvar p = 0; p < NUM_RD_PORTS; p++)
  begin : g_rd_chk
    a_rd_onehot: assert property (@(posedge clkGated) disable iff (reset)
      $onehot0(rd_addr_i[p]));
  end

  // Same for enabled write lines.
  for (genvar p = 0; p < NUM_WR_PORTS; p++)
  begin : g_wr_chk
    a_wr_onehot: assert property (@(posedge clkGated) disable iff (reset)
      wr_en_i[p] |-> $onehot0(wr_addr_i[p]));
  end

endmodule

// File: iq_free_list.sv
module iq_free_list (
  input  logic         clkGated,
  input  logic         reset,
  iq_entry_if.freelist ent
);
  import iq_pkg::*;

  // One busy bit per queue entry.
  logic [IQ_DEPTH-1:0] busy_q;
  logic [IQ_DEPTH-1:0] busy_d;

  // Free entries as a bit vector.
  logic [IQ_DEPTH-1:0] free_vec;

  // Bits set and cleared this cycle.
  logic [IQ_DEPTH-1:0] set_vec;
  logic [IQ_DEPTH-1:0] clr_vec;

  assign free_vec = ~busy_q;

  // Lowest free entry.
  // Adding one to busy_q ripples into the first zero.
  assign ent.alloc_onehot = free_vec & (busy_q + IQ_DEPTH'(1));

  // No free entry left.
  assign ent.full = &busy_q;

  // Allocation marks the slot busy.
  assign set_vec = ent.alloc_fire ? ent.alloc_onehot : '0;

  // Accepted issue releases the granted slot.
  assign clr_vec = ent.issue_fire ? ent.grant_onehot : '0;

  // Set and clear never hit the same entry.
  assign busy_d = (busy_q | set_vec) & ~clr_vec;

  always_ff @(posedge clkGated)
  begin
    if (reset)
    begin
      busy_q <= '0;
    end
    else
    begin
      busy_q <= busy_d;
    end
  end

  // Dispatch side fires only while a free slot is offered.
  a_alloc_free: assert property (@(posedge clkGated) disable iff (reset)
    ent.alloc_fire |-> !ent.full);

  // Select must only release entries that hold an op.
  a_issue_busy: assert property (@(posedge clkGated) disable iff (reset)
    ent.issue_fire |-> ((ent.grant_onehot & ~busy_q) == '0));

endmodule

// File: iq_wakeup_select.sv
module iq_wakeup_select (
  input  logic                clkGated,
  input  logic                reset,
  input  logic                dispatch_valid_i,
  input  iq_pkg::iq_payload_u dispatch_payload_i,
  input  logic                dispatch_src1_ready_i,
  input  logic                dispatch_src2_ready_i,
  input  logic                issue_ready_i,
  input  iq_pkg::iq_payload_u issued_payload_i,
  output logic                issue_valid_o,
  output logic                ram_wr_en_o,
  iq_entry_if.select          ent
);
  import iq_pkg::*;

  // Per-entry control state.
  logic [IQ_DEPTH-1:0] valid_q;
  logic [IQ_DEPTH-1:0] src1_rdy_q;
  logic [IQ_DEPTH-1:0] src2_rdy_q;

  // Per-entry source tags.
  logic [TAG_W-1:0] src1_tag_q [IQ_DEPTH];
  logic [TAG_W-1:0] src2_tag_q [IQ_DEPTH];

  // Tag broadcast from the issuing op.
  logic [TAG_W-1:0] bcast_tag;

  // Tag compare hits per entry.
  logic [IQ_DEPTH-1:0] src1_hit;
  logic [IQ_DEPTH-1:0] src2_hit;

  // Dispatch side readiness after bypass.
  logic disp_is_imm;
  logic disp_src1_rdy;
  logic disp_src2_rdy;

  // Entries with every source ready.
  logic [IQ_DEPTH-1:0] entry_rdy;

  // Dispatch handshake.
  assign ent.alloc_fire = dispatch_valid_i & ~ent.full;
  assign ram_wr_en_o    = dispatch_valid_i & ~ent.full;

  // Dest field sits at the same place in both views.
  assign bcast_tag = issued_payload_i.reg_form.dest;

  // Wakeup compare.
  // Only live during an accepted issue.
  always_comb
  begin
    for (int i = 0; i < IQ_DEPTH; i++)
    begin
      src1_hit[i] = ent.issue_fire && (src1_tag_q[i] == bcast_tag);
      src2_hit[i] = ent.issue_fire && (src2_tag_q[i] == bcast_tag);
    end
  end

  // Bypass for an op dispatched while its producer issues.
  assign disp_is_imm   = (dispatch_payload_i.reg_form.fmt == FMT_IMM);
  assign disp_src1_rdy = dispatch_src1_ready_i
                       | (ent.issue_fire && (dispatch_payload_i.reg_form.src1 == bcast_tag));
  // Immediate form has no second source.
  assign disp_src2_rdy = disp_is_imm
                       | dispatch_src2_ready_i
                       | (ent.issue_fire && (dispatch_payload_i.reg_form.src2 == bcast_tag));

  // Request vector.
  assign entry_rdy = valid_q & src1_rdy_q & src2_rdy_q;

  // Lowest set bit wins.
  assign ent.grant_onehot = entry_rdy & (~entry_rdy + IQ_DEPTH'(1));

  assign issue_valid_o  = |entry_rdy;
  assign ent.issue_fire = issue_valid_o & issue_ready_i;

  // Valid and ready bits.
  always_ff @(posedge clkGated)
  begin
    if (reset)
    begin
      valid_q    <= '0;
      src1_rdy_q <= '0;
      src2_rdy_q <= '0;
    end
    else
    begin
      for (int i = 0; i < IQ_DEPTH; i++)
      begin
        if (ent.alloc_fire && ent.alloc_onehot[i])
        begin
          valid_q[i]    <= 1'b1;
          src1_rdy_q[i] <= disp_src1_rdy;
          src2_rdy_q[i] <= disp_src2_rdy;
        end
        else
        begin
          // Leaves the queue on accepted issue.
          if (ent.issue_fire && ent.grant_onehot[i])
          begin
            valid_q[i] <= 1'b0;
          end
          if (src1_hit[i])
          begin
            src1_rdy_q[i] <= 1'b1;
          end
          if (src2_hit[i])
          begin
            src2_rdy_q[i] <= 1'b1;
          end
        end
      end
    end
  end

  // Tags captured at dispatch.
  always_ff @(posedge clkGated)
  begin
    for (int i = 0; i < IQ_DEPTH; i++)
    begin
      if (ent.alloc_fire && ent.alloc_onehot[i])
      begin
        src1_tag_q[i] <= dispatch_payload_i.reg_form.src1;
        src2_tag_q[i] <= dispatch_payload_i.reg_form.src2;
      end
    end
  end

  // Grant never points at a slot the free list still offers.
  a_grant_valid: assert property (@(posedge clkGated) disable iff (reset)
    (ent.grant_onehot & ent.alloc_onehot) == '0);

endmodule

// File: issue_queue.sv
module issue_queue (
  input  logic                clkGated,
  input  logic                reset,
  input  logic                dispatch_valid_i,
  output logic                dispatch_ready_o,
  input  iq_pkg::iq_payload_u dispatch_payload_i,
  input  logic                dispatch_src1_ready_i,
  input  logic                dispatch_src2_ready_i,
  output logic                issue_valid_o,
  input  logic                issue_ready_i,
  output iq_pkg::iq_payload_u issue_payload_o
);

  // RAM write strobe from the dispatch handshake.
  logic ram_wr_en;

  // Links free list and select.
  iq_entry_if u_entry_if ();

  // Back-pressure toward dispatch.
  assign dispatch_ready_o = ~u_entry_if.full;

  // Busy tracking and slot allocation.
  iq_free_list u_iq_free_list (
    .clkGated (clkGated),
    .reset    (reset),
    .ent      (u_entry_if.freelist)
  );

  // Operand readiness and grant.
  // Broadcast tag comes back from the RAM read.
  iq_wakeup_select u_iq_wakeup_select (
    .clkGated              (clkGated),
    .reset                 (reset),
    .dispatch_valid_i      (dispatch_valid_i),
    .dispatch_payload_i    (dispatch_payload_i),
    .dispatch_src1_ready_i (dispatch_src1_ready_i),
    .dispatch_src2_ready_i (dispatch_src2_ready_i),
    .issue_ready_i         (issue_ready_i),
    .issued_payload_i      (issue_payload_o),
    .issue_valid_o         (issue_valid_o),
    .ram_wr_en_o           (ram_wr_en),
    .ent                   (u_entry_if.select)
  );

  // Payload store.
  // Written on the alloc slot, read on the grant.
  one_hot_ram #(
    .NUM_RD_PORTS (1),
    .NUM_WR_PORTS (1)
  ) u_one_hot_ram (
    .clkGated  (clkGated),
    .reset     (reset),
    .rd_addr_i (u_entry_if.grant_onehot),
    .rd_data_o (issue_payload_o),
    .wr_addr_i (u_entry_if.alloc_onehot),
    .wr_data_i (dispatch_payload_i),
    .wr_en_i   (ram_wr_en)
  );

endmodule

// File: tb_issue_queue.sv
module tb_issue_queue;
  timeunit 1ns;
  timeprecision 100ps;
  import iq_pkg::*;

  localparam int MAX_OPS    = 512;
  localparam int WAIT_LIMIT = 2000;

  logic        clkGated;
  logic        reset;
  logic        dispatch_valid_i;
  logic        dispatch_ready_o;
  iq_payload_u dispatch_payload_i;
  logic        dispatch_src1_ready_i;
  logic        dispatch_src2_ready_i;
  logic        issue_valid_o;
  logic        issue_ready_i;
  iq_payload_u issue_payload_o;

  // Every dispatched op, in dispatch order.
  iq_payload_u ops [MAX_OPS];
  logic        op_r1 [MAX_OPS];
  logic        op_r2 [MAX_OPS];
  int          issue_cnt [MAX_OPS];
  int          num_ops;

  int     errors;
  int     tests_run;
  int     tests_bad;
  int     issued_total;
  integer seed;
  // Random issue_ready_i stalls, driven from the stimulus process.
  logic   rand_stall;

  issue_queue u_issue_queue (
    .clkGated              (clkGated),
    .reset                 (reset),
    .dispatch_valid_i      (dispatch_valid_i),
    .dispatch_ready_o      (dispatch_ready_o),
    .dispatch_payload_i    (dispatch_payload_i),
    .dispatch_src1_ready_i (dispatch_src1_ready_i),
    .dispatch_src2_ready_i (dispatch_src2_ready_i),
    .issue_valid_o         (issue_valid_o),
    .issue_ready_i         (issue_ready_i),
    .issue_payload_o       (issue_payload_o)
  );

  always #10 clkGated = ~clkGated;

  // Latest op before idx that writes tag, or -1.
  function automatic int last_producer(input int idx, input logic [TAG_W-1:0] tag);
    int found;
    found = -1;
    for (int j = 0; j < idx; j++)
      if (ops[j].reg_form.dest == tag) found = j;
    return found;
  endfunction

  // Reference rule.
  // A source not ready at dispatch needs its producer issued first.
  function automatic logic may_issue(input int idx);
    logic ok;
    int   prod;
    ok   = 1'b1;
    prod = last_producer(idx, ops[idx].reg_form.src1);
    if (!op_r1[idx] && (prod < 0 || issue_cnt[prod] == 0)) ok = 1'b0;
    // Immediate form has no second source.
    if (ops[idx].reg_form.fmt == FMT_REG && !op_r2[idx])
    begin
      prod = last_producer(idx, ops[idx].reg_form.src2);
      if (prod < 0 || issue_cnt[prod] == 0) ok = 1'b0;
    end
    return ok;
  endfunction

  // Dispatched op with this dest still waiting to issue, or -1.
  function automatic int find_waiting(input logic [TAG_W-1:0] tag);
    for (int j = 0; j < num_ops; j++)
      if (issue_cnt[j] == 0 && ops[j].reg_form.dest == tag) return j;
    return -1;
  endfunction

  function automatic int waiting_count();
    int n;
    n = 0;
    for (int j = 0; j < num_ops; j++)
      if (issue_cnt[j] == 0) n++;
    return n;
  endfunction

  // Half the time a random waiting op as producer.
  function automatic int pick_dep();
    int cand [$];
    if (($random(seed) & 1) == 0) return -1;
    for (int j = 0; j < num_ops; j++)
      if (issue_cnt[j] == 0) cand.push_back(j);
    if (cand.size() == 0) return -1;
    return cand[($random(seed) & 32'h7fff_ffff) % cand.size()];
  endfunction

  task automatic check_payload(input string name, input iq_payload_u got,
                               input iq_payload_u exp);
    if (got !== exp)
    begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("ERROR timeout while %s", what);
    $display("Simulation failed");
    $finish;
  endtask

  // Starts and ends on a falling edge.
  // dep1 and dep2 name producer ops, -1 for a ready source.
  task automatic dispatch_op(input logic imm, input int dep1, input int dep2);
    iq_payload_u      p;
    logic             r1;
    logic             r2;
    logic [TAG_W-1:0] tag;
    int               t;
    t = 0;
    if (rand_stall) issue_ready_i = ($random(seed) & 3) != 0;
    while (!dispatch_ready_o)
    begin
      if (t >= WAIT_LIMIT) abort_run("waiting for dispatch_ready_o");
      @(negedge clkGated);
      if (rand_stall) issue_ready_i = ($random(seed) & 3) != 0;
      t++;
    end
    // Dest tag unique among waiting ops.
    tag = TAG_W'($random(seed));
    while (find_waiting(tag) >= 0) tag = tag + TAG_W'(1);
    p.reg_form.fmt    = imm ? FMT_IMM : FMT_REG;
    p.reg_form.opcode = OPC_W'($random(seed));
    p.reg_form.dest   = tag;
    p.reg_form.src1   = TAG_W'($random(seed));
    if (imm) p.imm_form.imm = IMM_W'($random(seed));
    else p.reg_form.src2 = TAG_W'($random(seed));
    r1 = 1'b1;
    r2 = 1'b1;
    // A producer already gone counts as ready.
    if (dep1 >= 0 && issue_cnt[dep1] == 0)
    begin
      p.reg_form.src1 = ops[dep1].reg_form.dest;
      r1 = 1'b0;
    end
    if (!imm && dep2 >= 0 && issue_cnt[dep2] == 0)
    begin
      p.reg_form.src2 = ops[dep2].reg_form.dest;
      r2 = 1'b0;
    end
    ops[num_ops]       = p;
    op_r1[num_ops]     = r1;
    op_r2[num_ops]     = r2;
    issue_cnt[num_ops] = 0;
    num_ops++;
    dispatch_payload_i    = p;
    dispatch_src1_ready_i = r1;
    dispatch_src2_ready_i = r2;
    dispatch_valid_i      = 1'b1;
    // Ready was high, so the next rising edge takes it.
    @(negedge clkGated);
    dispatch_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (waiting_count() > 0)
    begin
      if (t >= WAIT_LIMIT) abort_run("draining the queue");
      @(negedge clkGated);
      t++;
    end
  endtask

  task automatic wait_issue_valid();
    int t;
    t = 0;
    while (!issue_valid_o)
    begin
      if (t >= WAIT_LIMIT) abort_run("waiting for issue_valid_o");
      @(negedge clkGated);
      t++;
    end
  endtask

  task automatic check_all_once(input int first);
    for (int j = first; j < num_ops; j++)
      if (issue_cnt[j] != 1)
      begin
        $display("ERROR op %0d issued %0d times", j, issue_cnt[j]);
        errors++;
      end
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) $display("test %0d %s: ok", tests_run, name);
    else
    begin
      tests_bad++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err0);
    end
  endtask

  // Every accepted issue against the reference.
  always @(posedge clkGated)
  begin : compare
    int idx;
    if (!reset && issue_valid_o && issue_ready_i)
    begin
      // Latest op with this dest, waiting or already issued.
      idx = last_producer(num_ops, issue_payload_o.reg_form.dest);
      if (idx < 0)
      begin
        $display("ERROR issued op with dest %h matches no dispatched op",
                 issue_payload_o.reg_form.dest);
        errors++;
      end
      else
      begin
        check_payload("issue_payload_o", issue_payload_o, ops[idx]);
        if (!may_issue(idx))
        begin
          $display("ERROR op %0d issued before its producer", idx);
          errors++;
        end
        issue_cnt[idx]++;
        issued_total++;
      end
    end
  end

  initial
  begin
    int          err0;
    int          first;
    iq_payload_u held;
    int          d1;
    int          d2;
    seed = 60;
    errors = 0;
    tests_run = 0;
    tests_bad = 0;
    issued_total = 0;
    num_ops = 0;
    rand_stall = 1'b0;
    clkGated = 1'b0;
    reset = 1'b1;
    dispatch_valid_i = 1'b0;
    dispatch_payload_i = '0;
    dispatch_src1_ready_i = 1'b0;
    dispatch_src2_ready_i = 1'b0;
    issue_ready_i = 1'b0;
    repeat (16) @(posedge clkGated);
    @(negedge clkGated);
    reset = 1'b0;

    // Empty queue, then independent ops in both forms.
    err0 = errors;
    first = num_ops;
    check_flag("dispatch_ready_o", dispatch_ready_o, 1'b1);
    check_flag("issue_valid_o", issue_valid_o, 1'b0);
    issue_ready_i = 1'b1;
    for (int i = 0; i < 6; i++) dispatch_op(i[0], -1, -1);
    wait_drain();
    check_all_once(first);
    report_test("reset and independent ops", err0);

    // Chain A, B on A, C on B and A, imm D on C.
    err0 = errors;
    first = num_ops;
    dispatch_op(1'b0, -1, -1);
    dispatch_op(1'b0, first, -1);
    dispatch_op(1'b0, first + 1, first);
    dispatch_op(1'b1, first + 2, -1);
    wait_drain();
    // Consumer dispatched on the producer's issue edge.
    issue_ready_i = 1'b0;
    dispatch_op(1'b0, -1, -1);
    wait_issue_valid();
    issue_ready_i = 1'b1;
    dispatch_op(1'b1, num_ops - 1, -1);
    wait_drain();
    check_all_once(first);
    report_test("dependency chains", err0);

    // Fill while stalled.
    err0 = errors;
    first = num_ops;
    issue_ready_i = 1'b0;
    for (int i = 0; i < IQ_DEPTH; i++) dispatch_op(i[0], -1, -1);
    repeat (3) @(negedge clkGated);
    check_flag("dispatch_ready_o", dispatch_ready_o, 1'b0);
    check_flag("issue_valid_o", issue_valid_o, 1'b1);
    issue_ready_i = 1'b1;
    wait_drain();
    check_all_once(first);
    report_test("full queue", err0);

    // Grant holds while later ops land above it.
    err0 = errors;
    first = num_ops;
    issue_ready_i = 1'b0;
    dispatch_op(1'b1, -1, -1);
    wait_issue_valid();
    held = issue_payload_o;
    check_payload("issue_payload_o", held, ops[first]);
    for (int i = 0; i < 4; i++)
    begin
      dispatch_op(i[0], -1, -1);
      check_flag("issue_valid_o", issue_valid_o, 1'b1);
      check_payload("issue_payload_o", issue_payload_o, held);
    end
    issue_ready_i = 1'b1;
    wait_drain();
    check_all_once(first);
    report_test("stable payload under stall", err0);

    // Random forms, dependencies and stalls.
    err0 = errors;
    first = num_ops;
    rand_stall = 1'b1;
    for (int i = 0; i < 300; i++)
    begin
      d1 = pick_dep();
      d2 = pick_dep();
      dispatch_op(logic'($random(seed) & 1), d1, d2);
    end
    rand_stall = 1'b0;
    issue_ready_i = 1'b1;
    wait_drain();
    check_all_once(first);
    report_test("random mix", err0);

    $display("%0d tests run, %0d with errors, %0d errors, %0d ops issued",
             tests_run, tests_bad, errors, issued_total);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: verilog.f
iq_pkg.sv
iq_entry_if.sv
one_hot_ram.sv
iq_free_list.sv
iq_wakeup_select.sv
issue_queue.sv
tb_issue_queue.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_issue_queue
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
